/* tsc_decode.f */
+incdir+dv
hdl/tsc_pkg.sv
hdl/inst_fetch.sv
hdl/inst_queue.sv
hdl/ctrl_decode.sv
hdl/tsc_decode_top.sv
dv/tsc_decode_tb.sv

/* Bender.yml */
package:
  name: tsc_decode

sources:
  - hdl/tsc_pkg.sv
  - hdl/inst_fetch.sv
  - hdl/inst_queue.sv
  - hdl/ctrl_decode.sv
  - hdl/tsc_decode_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tsc_decode_tb.sv

/* dv/decode_model.svh */
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// nop and hlt are consumed without leaving a bundle
function automatic bit yields_bundle(input logic [15:0] inst);
	bit is_nop;
	bit is_hlt;
	is_nop = (inst[15:12] == 4'd11);
	is_hlt = (inst[15:12] == 4'd15) && (inst[5:0] == 6'd29);
	return !is_nop && !is_hlt;
endfunction

// expected control bundle for one instruction at pc
function automatic tsc_pkg::ctrl_bundle_t expected_bundle(input logic [15:0] pc,
		input logic [15:0] inst);
	tsc_pkg::ctrl_bundle_t b;
	logic [3:0] op;
	logic [5:0] fn;
	bit rtype;
	bit alu_fn;
	bit jr_fn;
	bit jrl_fn;
	op     = inst[15:12];
	fn     = inst[5:0];
	rtype  = (op == 4'd15);
	alu_fn = rtype && (fn < 6'd8);
	jr_fn  = rtype && (fn == 6'd25 || fn == 6'd26);
	jrl_fn = rtype && (fn == 6'd26);
	b      = '0;
	b.pc   = pc;
	b.inst = inst;
	// adi ori lhi lwd swd, plus compare against zero
	b.ex.alu_src_b  = (op >= 4'd4 && op <= 4'd8) || op == 4'd2 || op == 4'd3;
	b.ex.alu_rtype  = rtype;
	b.mem.mem_read  = (op == 4'd7);
	b.mem.mem_write = (op == 4'd8);
	b.mem.pc_br     = (op <= 4'd3);
	b.mem.pc_j      = (op == 4'd9) || (op == 4'd10) || jr_fn;
	b.mem.pc_jr     = jr_fn;
	b.wb.mem_to_reg = (op == 4'd7);
	b.wb.reg_write  = alu_fn || (op >= 4'd4 && op <= 4'd7) || op == 4'd10 || jrl_fn;
	b.wb.pc_to_reg  = (op == 4'd10) || jrl_fn;
	b.wb.is_lhi     = (op == 4'd6);
	b.wwd           = rtype && (fn == 6'd28);
	return b;
endfunction

`endif

/* dv/tsc_decode_tb.sv */
`timescale 1ns/100ps

module tsc_decode_tb;

	import tsc_pkg::*;

	`include "decode_model.svh"

	logic                 reset_n;
	logic                 rst;
	logic                 stall;
	logic                 flush;
	logic [word_size-1:0] redirect_pc;
	logic [word_size-1:0] imem_addr;
	logic [word_size-1:0] imem_data;
	logic                 ctrl_valid;
	ctrl_bundle_t         ctrl;
	logic                 halt;

	logic [word_size-1:0] imem [65536];
	integer               seed;
	int                   errors;
	int                   bundles_seen;
	int                   nops_skipped;
	logic [word_size-1:0] exp_pc;
	logic                 prev_stall;
	logic                 prev_flush;

	// asynchronous instruction memory
	assign imem_data = imem[imem_addr];

	tsc_decode_top UUT (
		.reset_n     (reset_n),
		.rst         (rst),
		.imem_data   (imem_data),
		.stall       (stall),
		.flush       (flush),
		.redirect_pc (redirect_pc),
		.imem_addr   (imem_addr),
		.ctrl_valid  (ctrl_valid),
		.ctrl        (ctrl),
		.halt        (halt)
	);

	initial begin
		reset_n = 1'b0;
		forever #2 reset_n = ~reset_n;
	end

	// region 0 and 3 alu mix, region 1 control flow, region 2 half nops
	function automatic logic [15:0] legal_inst(input logic [1:0] region, input logic [31:0] r);
		logic [2:0] sel;
		sel = r[18:16];
		if (region == 2'd1) begin
			case (sel)
				3'd4: return {4'd9, r[11:0]};
				3'd5: return {4'd10, r[11:0]};
				3'd6: return {4'd15, r[11:6], (r[0] ? 6'd26 : 6'd25)};
				3'd7: return {4'd15, r[11:6], 6'd28};
				default: return {2'b00, sel[1:0], r[11:0]};
			endcase
		end
		if (region == 2'd2 && r[20]) begin
			return {4'd11, r[11:0]};
		end
		case (sel)
			3'd0: return {4'd4, r[11:0]};
			3'd1: return {4'd5, r[11:0]};
			3'd2: return {4'd6, r[11:0]};
			3'd3: return {4'd7, r[11:0]};
			3'd4: return {4'd8, r[11:0]};
			default: return {4'd15, r[11:6], 3'b000, r[2:0]};
		endcase
	endfunction

	// mid-cycle compare of every bundle against the reference
	always @(negedge reset_n) begin : compare
		ctrl_bundle_t exp_b;
		if (!rst) begin
			if (ctrl_valid) begin
				assert (!halt) else begin
					$display("[FAIL] %0t bundle at pc %h after halt", $time, ctrl.pc);
					errors++;
				end
				assert (!prev_stall && !prev_flush) else begin
					$display("[FAIL] %0t bundle after a stall or flush cycle", $time);
					errors++;
				end
				for (int i = 0; i < 64 && !yields_bundle(imem[exp_pc]); i++) begin
					exp_pc = exp_pc + 16'd1;
					nops_skipped++;
				end
				exp_b = expected_bundle(exp_pc, imem[exp_pc]);
				assert (ctrl.pc == exp_pc) else begin
					$display("[FAIL] %0t pc %h, expected %h", $time, ctrl.pc, exp_pc);
					errors++;
				end
				assert (ctrl == exp_b) else begin
					$display("[FAIL] %0t bundle %h, expected %h", $time, ctrl, exp_b);
					errors++;
				end
				exp_pc = exp_pc + 16'd1;
				bundles_seen++;
			end
			// the stream restarts at the redirect target
			if (flush) begin
				exp_pc = redirect_pc;
			end
			prev_stall = stall;
			prev_flush = flush;
		end
	end

	// wait for n more bundles, with random stall stretches if asked
	task automatic run_bundles(input int n, input bit with_stall);
		int          target;
		int          cycles;
		int          stretch;
		logic [31:0] rnd;
		target  = bundles_seen + n;
		cycles  = 0;
		stretch = 0;
		while (bundles_seen < target && cycles < 200 * n + 100) begin
			@(posedge reset_n);
			if (with_stall) begin
				if (stretch == 0) begin
					rnd     = $random(seed);
					stall   <= rnd[0];
					stretch = 1 + (rnd[10:8] % 8);
				end
				stretch--;
			end
			cycles++;
		end
		stall <= 1'b0;
		assert (bundles_seen >= target) else begin
			$display("timeout: %0d cycles passed without %0d more bundles", cycles, n);
			errors++;
		end
	endtask

	task automatic do_flush(input logic [15:0] pc);
		@(posedge reset_n);
		flush       <= 1'b1;
		redirect_pc <= pc;
		@(posedge reset_n);
		flush <= 1'b0;
	endtask

	task automatic report_test(input string name, input int err_before);
		$display("test %s done: %0d bundles so far, %0d new errors",
			name, bundles_seen, errors - err_before);
	endtask

	initial begin
		int          e0;
		int          b0;
		int          live;
		int          cycles;
		int          skipped0;
		logic [31:0] rnd;
		logic [15:0] addr_at_halt;
		seed         = 32'hd8beefd7;
		rst          = 1'b1;
		stall        = 1'b0;
		flush        = 1'b0;
		redirect_pc  = '0;
		errors       = 0;
		bundles_seen = 0;
		nops_skipped = 0;
		exp_pc       = '0;
		prev_stall   = 1'b0;
		prev_flush   = 1'b0;
		for (int a = 0; a < 65536; a++) begin
			rnd     = $random(seed);
			imem[a] = legal_inst(2'(a >> 14), rnd);
		end
		repeat (8) @(posedge reset_n);
		rst <= 1'b0;

		e0 = errors;
		run_bundles(40, 1'b0);
		report_test("1 alu mix", e0);

		e0 = errors;
		do_flush(16'h4000);
		run_bundles(40, 1'b0);
		report_test("2 control flow", e0);

		e0 = errors;
		do_flush(16'hc000);
		run_bundles(60, 1'b1);
		report_test("3 random stall", e0);

		e0 = errors;
		for (int k = 0; k < 8; k++) begin
			rnd = $random(seed);
			run_bundles(1 + (rnd[7:0] % 6), 1'b0);
			do_flush(rnd[31:16] & 16'h7fff);
		end
		run_bundles(4, 1'b0);
		report_test("4 flush redirect", e0);

		e0       = errors;
		skipped0 = nops_skipped;
		do_flush(16'h8000);
		run_bundles(40, 1'b0);
		assert (nops_skipped > skipped0) else begin
			$display("[FAIL] %0t no nop word was skipped in the nop region", $time);
			errors++;
		end
		report_test("5 nop skip", e0);

		e0 = errors;
		imem[16'he008] = 16'hf01d;
		do_flush(16'he000);
		b0   = bundles_seen;
		live = 0;
		for (int a = 16'he000; a < 16'he008; a++) begin
			live += yields_bundle(imem[a]);
		end
		cycles = 0;
		while (!halt && cycles < 200) begin
			@(negedge reset_n);
			cycles++;
		end
		assert (halt) else begin
			$display("timeout: halt never rose after the hlt word");
			errors++;
		end
		assert (bundles_seen - b0 == live) else begin
			$display("[FAIL] %0t %0d bundles before hlt, expected %0d",
				$time, bundles_seen - b0, live);
			errors++;
		end
		// fetch drains its remaining credits, then sits still
		repeat (4 * queue_depth) @(negedge reset_n);
		addr_at_halt = imem_addr;
		repeat (10) @(negedge reset_n);
		assert (halt && imem_addr == addr_at_halt) else begin
			$display("[FAIL] %0t fetch moved to %h after halt", $time, imem_addr);
			errors++;
		end
		assert (addr_at_halt <= 16'he008 + 1 + queue_depth) else begin
			$display("[FAIL] %0t fetch ran to %h past the hlt word", $time, addr_at_halt);
			errors++;
		end
		report_test("6 halt", e0);

		$display("summary: %0d bundles checked, %0d errors", bundles_seen, errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

/* hdl/tsc_decode_top.sv */
`timescale 1ns/100ps

module tsc_decode_top (
	input  logic                          reset_n,
	input  logic                          rst,
	input  logic [tsc_pkg::word_size-1:0] imem_data,
	input  logic                          stall,
	input  logic                          flush,
	input  logic [tsc_pkg::word_size-1:0] redirect_pc,
	output logic [tsc_pkg::word_size-1:0] imem_addr,
	output logic                          ctrl_valid,
	output tsc_pkg::ctrl_bundle_t         ctrl,
	output logic                          halt
);

	import tsc_pkg::*;

	// fetch to queue, credit based
	logic         push;
	fetch_entry_t push_entry;
	logic         credit_return;

	// queue to decode
	logic         head_valid;
	fetch_entry_t head_entry;
	logic         pop;

	inst_fetch u_fetch (
		.reset_n       (reset_n),
		.rst           (rst),
		.flush         (flush),
		.redirect_pc   (redirect_pc),
		.imem_data     (imem_data),
		.credit_return (credit_return),
		.imem_addr     (imem_addr),
		.push          (push),
		.push_entry    (push_entry)
	);

	inst_queue u_queue (
		.reset_n       (reset_n),
		.rst           (rst),
		.flush         (flush),
		.push          (push),
		.push_entry    (push_entry),
		.pop           (pop),
		.head_valid    (head_valid),
		.head_entry    (head_entry),
		.credit_return (credit_return)
	);

	ctrl_decode u_decode (
		.reset_n    (reset_n),
		.rst        (rst),
		.stall      (stall),
		.flush      (flush),
		.head_valid (head_valid),
		.head_entry (head_entry),
		.pop        (pop),
		.ctrl_valid (ctrl_valid),
		.ctrl       (ctrl),
		.halt       (halt)
	);

endmodule

/* hdl/ctrl_decode.sv */
`timescale 1ns/100ps

module ctrl_decode (
	input  logic                  reset_n,
	input  logic                  rst,
	input  logic                  stall,
	input  logic                  flush,
	input  logic                  head_valid,
	input  tsc_pkg::fetch_entry_t head_entry,
	output logic                  pop,
	output logic                  ctrl_valid,
	output tsc_pkg::ctrl_bundle_t ctrl,
	output logic                  halt
);

	import tsc_pkg::*;

	opcode_e      op;
	funct_e       fn;
	logic         is_nop;
	logic         is_hlt;
	ctrl_bundle_t dec;

	// stall keeps the head, flush drops it, halt ends decoding for good
	assign pop = head_valid && !stall && !flush && !halt;

	assign op     = opcode_e'(head_entry.inst[15:12]);
	assign fn     = funct_e'(head_entry.inst[5:0]);
	assign is_nop = (op == op_nop);
	assign is_hlt = (op == op_rtype) && (fn == fn_hlt);

	always_comb begin
		dec      = '0;
		dec.pc   = head_entry.pc;
		dec.inst = head_entry.inst;
		case (op)
			op_bne, op_beq: begin
				dec.mem.pc_br = 1'b1;
			end
			// compare against zero uses the immediate path
			op_bgz, op_blz: begin
				dec.ex.alu_src_b = 1'b1;
				dec.mem.pc_br    = 1'b1;
			end
			op_adi, op_ori: begin
				dec.ex.alu_src_b = 1'b1;
				dec.wb.reg_write = 1'b1;
			end
			op_lhi: begin
				dec.ex.alu_src_b = 1'b1;
				dec.wb.reg_write = 1'b1;
				dec.wb.is_lhi    = 1'b1;
			end
			op_lwd: begin
				dec.ex.alu_src_b  = 1'b1;
				dec.mem.mem_read  = 1'b1;
				dec.wb.mem_to_reg = 1'b1;
				dec.wb.reg_write  = 1'b1;
			end
			op_swd: begin
				dec.ex.alu_src_b  = 1'b1;
				dec.mem.mem_write = 1'b1;
			end
			op_jmp: begin
				dec.mem.pc_j = 1'b1;
			end
			// link register gets the return address
			op_jal: begin
				dec.mem.pc_j     = 1'b1;
				dec.wb.reg_write = 1'b1;
				dec.wb.pc_to_reg = 1'b1;
			end
			op_rtype: begin
				dec.ex.alu_rtype = 1'b1;
				case (fn)
					fn_add, fn_sub, fn_and, fn_orr, fn_not, fn_tcp, fn_shl, fn_shr: begin
						dec.wb.reg_write = 1'b1;
					end
					fn_jpr: begin
						dec.mem.pc_j  = 1'b1;
						dec.mem.pc_jr = 1'b1;
					end
					fn_jrl: begin
						dec.mem.pc_j     = 1'b1;
						dec.mem.pc_jr    = 1'b1;
						dec.wb.reg_write = 1'b1;
						dec.wb.pc_to_reg = 1'b1;
					end
					fn_wwd: begin
						dec.wwd = 1'b1;
					end
					default: begin
					end
				endcase
			end
			default: begin
			end
		endcase
	end

	// bundle payload only moves on a pop
	always_ff @(posedge reset_n) begin
		if (pop) begin
			ctrl <= dec;
		end
	end

	always_ff @(posedge reset_n) begin
		if (rst) begin
			ctrl_valid <= 1'b0;
			halt       <= 1'b0;
		end else begin
			ctrl_valid <= pop && !is_nop && !is_hlt;
			// sticky until reset
			if (pop && is_hlt) begin
				halt <= 1'b1;
			end
		end
	end

endmodule

/* hdl/inst_queue.sv */
`timescale 1ns/100ps

module inst_queue (
	input  logic                  reset_n,
	input  logic                  rst,
	input  logic                  flush,
	input  logic                  push,
	input  tsc_pkg::fetch_entry_t push_entry,
	input  logic                  pop,
	output logic                  head_valid,
	output tsc_pkg::fetch_entry_t head_entry,
	output logic                  credit_return
);

	import tsc_pkg::*;

	localparam int ptr_width = $clog2(queue_depth);

	fetch_entry_t            entries [queue_depth];
	logic [ptr_width-1:0]    rd_ptr;
	logic [ptr_width-1:0]    wr_ptr;
	logic [credit_width-1:0] count;

	assign head_valid = (count != '0);
	assign head_entry = entries[rd_ptr];

	// every popped slot goes straight back to fetch as a credit
	assign credit_return = pop && head_valid;

	// entry storage
	always_ff @(posedge reset_n) begin
		if (push) begin
			entries[wr_ptr] <= push_entry;
		end
	end

	always_ff @(posedge reset_n) begin
		if (rst || flush) begin
			// fetch reloads its own credits on flush
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				if (wr_ptr == ptr_width'(queue_depth - 1)) begin
					wr_ptr <= '0;
				end else begin
					wr_ptr <= wr_ptr + ptr_width'(1);
				end
			end
			if (credit_return) begin
				if (rd_ptr == ptr_width'(queue_depth - 1)) begin
					rd_ptr <= '0;
				end else begin
					rd_ptr <= rd_ptr + ptr_width'(1);
				end
			end
			count <= count + credit_width'(push) - credit_width'(credit_return);
		end
	end

endmodule

/* hdl/inst_fetch.sv */
`timescale 1ns/100ps

module inst_fetch (
	input  logic                           reset_n,
	input  logic                           rst,
	input  logic                           flush,
	input  logic [tsc_pkg::word_size-1:0]  redirect_pc,
	input  logic [tsc_pkg::word_size-1:0]  imem_data,
	input  logic                           credit_return,
	output logic [tsc_pkg::word_size-1:0]  imem_addr,
	output logic                           push,
	output tsc_pkg::fetch_entry_t          push_entry
);

	import tsc_pkg::*;

	logic [word_size-1:0]    pc;
	logic [credit_width-1:0] credits;
	logic                    fetch_en;

	// imem answers in the same cycle
	assign imem_addr = pc;

	// one push per cycle while a queue slot is known to be free
	assign push = fetch_en && (credits != '0) && !flush;

	always_comb begin
		push_entry.pc   = pc;
		push_entry.inst = imem_data;
	end

	always_ff @(posedge reset_n) begin
		if (rst) begin
			pc       <= '0;
			credits  <= credit_width'(queue_depth);
			fetch_en <= 1'b0;
		end else begin
			fetch_en <= 1'b1;
			if (flush) begin
				// queue empties on flush so every slot is free again
				pc      <= redirect_pc;
				credits <= credit_width'(queue_depth);
			end else begin
				if (push) begin
					pc <= pc + word_size'(1);
				end
				credits <= credits - credit_width'(push) + credit_width'(credit_return);
			end
		end
	end

endmodule

/* hdl/tsc_pkg.sv */
package tsc_pkg;

	// instruction and program counter width
	localparam int word_size = 16;

	// queue entries, also the credits fetch starts with
	localparam int queue_depth = 4;

	// wide enough to hold a full set of credits
	localparam int credit_width = $clog2(queue_depth + 1);

	// top nibble of the instruction
	typedef enum logic [3:0] {
		op_bne   = 4'd0,
		op_beq   = 4'd1,
		op_bgz   = 4'd2,
		op_blz   = 4'd3,
		op_adi   = 4'd4,
		op_ori   = 4'd5,
		op_lhi   = 4'd6,
		op_lwd   = 4'd7,
		op_swd   = 4'd8,
		op_jmp   = 4'd9,
		op_jal   = 4'd10,
		op_nop   = 4'd11,
		op_rtype = 4'd15
	} opcode_e;

	// low six bits of an rtype instruction
	typedef enum logic [5:0] {
		fn_add = 6'd0,
		fn_sub = 6'd1,
		fn_and = 6'd2,
		fn_orr = 6'd3,
		fn_not = 6'd4,
		fn_tcp = 6'd5,
		fn_shl = 6'd6,
		fn_shr = 6'd7,
		fn_jpr = 6'd25,
		fn_jrl = 6'd26,
		fn_wwd = 6'd28,
		fn_hlt = 6'd29
	} funct_e;

	// instruction word tagged with its address
	typedef struct packed {
		logic [word_size-1:0] pc;
		logic [word_size-1:0] inst;
	} fetch_entry_t;

	typedef struct packed {
		logic alu_src_b;
		logic alu_rtype;
	} ex_ctrl_t;

	typedef struct packed {
		logic mem_read;
		logic mem_write;
		logic pc_br;
		logic pc_j;
		logic pc_jr;
	} mem_ctrl_t;

	typedef struct packed {
		logic mem_to_reg;
		logic reg_write;
		logic pc_to_reg;
		logic is_lhi;
	} wb_ctrl_t;

	// everything the later stages need for one instruction
	typedef struct packed {
		logic [word_size-1:0] pc;
		logic [word_size-1:0] inst;
		ex_ctrl_t             ex;
		mem_ctrl_t            mem;
		wb_ctrl_t             wb;
		logic                 wwd;
	} ctrl_bundle_t;

endpackage
